// File: list.f
oc_pkg.sv
oc_if.sv
oc_regfile.sv
oc_alloc_stage.sv
oc_collect_stage.sv
oc_release_stage.sv
oc_top.sv
tb_clock.sv
oc_tb.sv

// File: oc_alloc_stage.sv
`timescale 1ns/1ps

module oc_alloc_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              dispatch_valid,
    input  oc_pkg::warp_t     dispatch_warp,
    input  oc_pkg::op_e       dispatch_op,
    input  oc_pkg::reg_idx_t  dispatch_rd,
    input  oc_pkg::reg_idx_t  dispatch_rs1,
    input  oc_pkg::reg_idx_t  dispatch_rs2,
    input  logic              free_valid,
    input  oc_pkg::unit_idx_t free_unit,
    oc_alloc_if.source        alloc,
    output logic              dispatch_credit
);

    logic [oc_pkg::NUM_UNITS-1:0] free_mask;
    oc_pkg::seq_t                 issue_cnt [oc_pkg::NUM_WARPS];
    oc_pkg::unit_idx_t            pick;
    oc_pkg::need_t                need;

    // Lowest free unit wins
    always_comb begin
        pick = '0;
        for (int u = oc_pkg::NUM_UNITS - 1; u >= 0; u--) begin
            if (free_mask[u]) begin
                pick = oc_pkg::unit_idx_t'(u);
            end
        end
    end

    // Opcode class to source mask, unknown opcodes read both
    always_comb begin
        case (dispatch_op)
            oc_pkg::OP_NOP, oc_pkg::OP_TID:                 need = 2'b00;
            oc_pkg::OP_MOV, oc_pkg::OP_NOT, oc_pkg::OP_NEG: need = 2'b01;
            default:                                        need = 2'b11;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            free_mask       <= '1;
            alloc.valid     <= 1'b0;
            dispatch_credit <= 1'b0;
            for (int w = 0; w < oc_pkg::NUM_WARPS; w++) begin
                issue_cnt[w] <= '0;
            end
        end else begin
            alloc.valid     <= dispatch_valid;
            // One credit back per freed unit, a cycle later
            dispatch_credit <= free_valid;
            if (free_valid) begin
                free_mask[free_unit] <= 1'b1;
            end
            if (dispatch_valid) begin
                free_mask[pick]          <= 1'b0;
                issue_cnt[dispatch_warp] <= issue_cnt[dispatch_warp] + 1'b1;
            end
        end
    end

    // Instruction fields ride along with valid
    always_ff @(posedge clk) begin
        if (dispatch_valid) begin
            alloc.unit <= pick;
            alloc.warp <= dispatch_warp;
            alloc.op   <= dispatch_op;
            alloc.rd   <= dispatch_rd;
            alloc.rs1  <= dispatch_rs1;
            alloc.rs2  <= dispatch_rs2;
            alloc.need <= need;
            alloc.seq  <= issue_cnt[dispatch_warp];
        end
    end

    // Upstream credit count must keep dispatch within the free pool
    a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
        dispatch_valid |-> |free_mask);

endmodule

// File: oc_collect_stage.sv
`timescale 1ns/1ps

module oc_collect_stage (
    input  logic          clk,
    input  logic          rst_n,
    oc_alloc_if.sink      alloc,
    oc_bank_if.source     bank,
    oc_release_if.source  rel
);

    // ==================================================
    // Unit table
    // ==================================================
    oc_pkg::unit_state_e state [oc_pkg::NUM_UNITS];
    oc_pkg::warp_t       warp  [oc_pkg::NUM_UNITS];
    oc_pkg::op_e         op    [oc_pkg::NUM_UNITS];
    oc_pkg::reg_idx_t    rd    [oc_pkg::NUM_UNITS];
    oc_pkg::reg_idx_t    rs1   [oc_pkg::NUM_UNITS];
    oc_pkg::reg_idx_t    rs2   [oc_pkg::NUM_UNITS];
    oc_pkg::need_t       need  [oc_pkg::NUM_UNITS];
    oc_pkg::seq_t        seq   [oc_pkg::NUM_UNITS];
    // Captured slots, and slots with a read in flight
    oc_pkg::need_t       got   [oc_pkg::NUM_UNITS];
    oc_pkg::need_t       pend  [oc_pkg::NUM_UNITS];
    oc_pkg::need_t       want  [oc_pkg::NUM_UNITS];
    oc_pkg::vreg_t       opnd  [oc_pkg::NUM_UNITS][2];

    // Per-bank arbitration and grant tracking
    oc_pkg::unit_idx_t   rr_ptr [oc_pkg::NUM_BANKS];
    logic                sel_v  [oc_pkg::NUM_BANKS];
    oc_pkg::unit_idx_t   sel_u  [oc_pkg::NUM_BANKS];
    logic                sel_s  [oc_pkg::NUM_BANKS];
    logic                gnt_v  [oc_pkg::NUM_BANKS];
    oc_pkg::unit_idx_t   gnt_u  [oc_pkg::NUM_BANKS];
    logic                gnt_s  [oc_pkg::NUM_BANKS];

    for (genvar u = 0; u < oc_pkg::NUM_UNITS; u++) begin : g_unit
        assign want[u]         = need[u] & ~got[u] & ~pend[u];
        assign rel.ready[u]    = (state[u] == oc_pkg::READY);
        assign rel.warp[u]     = warp[u];
        assign rel.seq[u]      = seq[u];
        assign rel.op[u]       = op[u];
        assign rel.rd[u]       = rd[u];
        assign rel.need[u]     = need[u];
        assign rel.rs1_data[u] = opnd[u][0];
        assign rel.rs2_data[u] = opnd[u][1];
    end

    // ==================================================
    // Bank arbitration, round robin from each pointer
    // ==================================================
    always_comb begin
        oc_pkg::unit_idx_t u;
        u = '0;
        for (int b = 0; b < oc_pkg::NUM_BANKS; b++) begin
            sel_v[b] = 1'b0;
            sel_u[b] = '0;
            sel_s[b] = 1'b0;
            for (int i = 0; i < oc_pkg::NUM_UNITS; i++) begin
                u = rr_ptr[b] + oc_pkg::unit_idx_t'(i);
                if (!sel_v[b] && state[u] == oc_pkg::COLLECTING) begin
                    // rs1 first when both slots sit in this bank
                    if (want[u][0] && oc_pkg::bank_of(rs1[u]) == oc_pkg::bank_t'(b)) begin
                        sel_v[b] = 1'b1;
                        sel_u[b] = u;
                    end else if (want[u][1] &&
                                 oc_pkg::bank_of(rs2[u]) == oc_pkg::bank_t'(b)) begin
                        sel_v[b] = 1'b1;
                        sel_u[b] = u;
                        sel_s[b] = 1'b1;
                    end
                end
            end
            bank.req[b]  = sel_v[b];
            bank.warp[b] = warp[sel_u[b]];
            bank.off[b]  = sel_s[b] ? oc_pkg::off_of(rs2[sel_u[b]])
                                    : oc_pkg::off_of(rs1[sel_u[b]]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int u = 0; u < oc_pkg::NUM_UNITS; u++) begin
                state[u] <= oc_pkg::IDLE;
                got[u]   <= '0;
                pend[u]  <= '0;
            end
            for (int b = 0; b < oc_pkg::NUM_BANKS; b++) begin
                gnt_v[b]  <= 1'b0;
                rr_ptr[b] <= '0;
            end
        end else begin
            // Ready once every needed slot is captured
            for (int u = 0; u < oc_pkg::NUM_UNITS; u++) begin
                if (state[u] == oc_pkg::COLLECTING && (got[u] & need[u]) == need[u]) begin
                    state[u] <= oc_pkg::READY;
                end
            end
            if (rel.free_valid) begin
                state[rel.free_unit] <= oc_pkg::IDLE;
            end
            for (int b = 0; b < oc_pkg::NUM_BANKS; b++) begin
                // Data for last cycle's grant is on rdata now
                if (gnt_v[b]) begin
                    got[gnt_u[b]][gnt_s[b]]  <= 1'b1;
                    pend[gnt_u[b]][gnt_s[b]] <= 1'b0;
                end
                gnt_v[b] <= sel_v[b];
                if (sel_v[b]) begin
                    pend[sel_u[b]][sel_s[b]] <= 1'b1;
                    rr_ptr[b]                <= sel_u[b] + 1'b1;
                end
            end
            if (alloc.valid) begin
                state[alloc.unit] <= oc_pkg::COLLECTING;
                got[alloc.unit]   <= '0;
                pend[alloc.unit]  <= '0;
            end
        end
    end

    // Payload, operand capture and instruction fields
    always_ff @(posedge clk) begin
        for (int b = 0; b < oc_pkg::NUM_BANKS; b++) begin
            gnt_u[b] <= sel_u[b];
            gnt_s[b] <= sel_s[b];
            if (gnt_v[b]) begin
                opnd[gnt_u[b]][gnt_s[b]] <= bank.rdata[b];
            end
        end
        if (alloc.valid) begin
            warp[alloc.unit] <= alloc.warp;
            op[alloc.unit]   <= alloc.op;
            rd[alloc.unit]   <= alloc.rd;
            rs1[alloc.unit]  <= alloc.rs1;
            rs2[alloc.unit]  <= alloc.rs2;
            need[alloc.unit] <= alloc.need;
            seq[alloc.unit]  <= alloc.seq;
        end
    end

    // Allocate stage free mask must agree with the unit table
    a_alloc_idle: assert property (@(posedge clk) disable iff (!rst_n)
        alloc.valid |-> state[alloc.unit] == oc_pkg::IDLE);

endmodule

// File: oc_if.sv
`timescale 1ns/1ps

// Allocate stage to collect stage, one new instruction per valid cycle
interface oc_alloc_if;
    logic              valid;
    oc_pkg::unit_idx_t unit;
    oc_pkg::warp_t     warp;
    oc_pkg::op_e       op;
    oc_pkg::reg_idx_t  rd;
    oc_pkg::reg_idx_t  rs1;
    oc_pkg::reg_idx_t  rs2;
    oc_pkg::need_t     need;
    oc_pkg::seq_t      seq;

    modport source (output valid, unit, warp, op, rd, rs1, rs2, need, seq);
    modport sink   (input  valid, unit, warp, op, rd, rs1, rs2, need, seq);
endinterface

// Collect stage to register file, one read slot per bank
interface oc_bank_if;
    logic [oc_pkg::NUM_BANKS-1:0] req;
    oc_pkg::warp_t                warp  [oc_pkg::NUM_BANKS];
    oc_pkg::off_t                 off   [oc_pkg::NUM_BANKS];
    // Valid the cycle after req
    oc_pkg::vreg_t                rdata [oc_pkg::NUM_BANKS];

    modport source (output req, warp, off, input  rdata);
    modport target (input  req, warp, off, output rdata);
endinterface

// Collect stage to release stage, per-unit view plus the free return path
interface oc_release_if;
    logic [oc_pkg::NUM_UNITS-1:0] ready;
    oc_pkg::warp_t                warp     [oc_pkg::NUM_UNITS];
    oc_pkg::seq_t                 seq      [oc_pkg::NUM_UNITS];
    oc_pkg::op_e                  op       [oc_pkg::NUM_UNITS];
    oc_pkg::reg_idx_t             rd       [oc_pkg::NUM_UNITS];
    oc_pkg::need_t                need     [oc_pkg::NUM_UNITS];
    oc_pkg::vreg_t                rs1_data [oc_pkg::NUM_UNITS];
    oc_pkg::vreg_t                rs2_data [oc_pkg::NUM_UNITS];
    logic                         free_valid;
    oc_pkg::unit_idx_t            free_unit;

    modport source (
        output ready, warp, seq, op, rd, need, rs1_data, rs2_data,
        input  free_valid, free_unit
    );
    modport sink (
        input  ready, warp, seq, op, rd, need, rs1_data, rs2_data,
        output free_valid, free_unit
    );
endinterface

// File: oc_pkg.sv
package oc_pkg;

    // ==================================================
    // Sizes
    // ==================================================
    localparam int LANES      = 4;
    localparam int DATA_W     = 16;
    localparam int NUM_WARPS  = 4;
    localparam int NUM_REGS   = 16;
    localparam int NUM_BANKS  = 4;
    localparam int BANK_DEPTH = 4;
    localparam int NUM_UNITS  = 4;
    // Must stay wider than the unit count so in-flight numbers never alias
    localparam int SEQ_W      = 4;
    localparam int EX_CREDITS = 2;

    // ==================================================
    // Vector types
    // ==================================================
    typedef logic [1:0]                  warp_t;
    typedef logic [3:0]                  reg_idx_t;
    typedef logic [1:0]                  bank_t;
    typedef logic [$clog2(BANK_DEPTH)-1:0] off_t;
    typedef logic [1:0]                  unit_idx_t;
    typedef logic [SEQ_W-1:0]            seq_t;
    typedef logic [LANES-1:0]            lane_mask_t;
    typedef logic [LANES*DATA_W-1:0]     vreg_t;
    // Bit 0 rs1, bit 1 rs2
    typedef logic [1:0]                  need_t;
    typedef logic [$clog2(EX_CREDITS+1)-1:0] credit_t;

    typedef enum logic [3:0] {
        OP_NOP = 4'h0,
        OP_TID = 4'h1,
        OP_MOV = 4'h2,
        OP_NOT = 4'h3,
        OP_NEG = 4'h4,
        OP_ADD = 4'h5,
        OP_SUB = 4'h6,
        OP_AND = 4'h7,
        OP_OR  = 4'h8,
        OP_MUL = 4'h9
    } op_e;

    typedef enum logic [1:0] {
        IDLE,
        COLLECTING,
        READY
    } unit_state_e;

    // Interleaved banking, low index bits pick the bank
    function automatic bank_t bank_of(reg_idx_t r);
        return r[1:0];
    endfunction

    function automatic off_t off_of(reg_idx_t r);
        return r[3:2];
    endfunction

endpackage

// File: oc_regfile.sv
`timescale 1ns/1ps

module oc_regfile (
    input  logic               clk,
    input  logic               rst_n,
    oc_bank_if.target          bank,
    input  logic               wb_valid,
    input  oc_pkg::warp_t      wb_warp,
    input  oc_pkg::reg_idx_t   wb_rd,
    input  oc_pkg::lane_mask_t wb_mask,
    input  oc_pkg::vreg_t      wb_data
);

    oc_pkg::bank_t wb_bank;
    oc_pkg::off_t  wb_off;

    assign wb_bank = oc_pkg::bank_of(wb_rd);
    assign wb_off  = oc_pkg::off_of(wb_rd);

    for (genvar b = 0; b < oc_pkg::NUM_BANKS; b++) begin : g_bank
        oc_pkg::vreg_t mem [oc_pkg::NUM_WARPS][oc_pkg::BANK_DEPTH];
        oc_pkg::vreg_t rdata_q;
        logic          wr_hit;
        logic          same_row;

        assign wr_hit   = wb_valid && (wb_bank == oc_pkg::bank_t'(b));
        // Writeback targets the row being read this cycle
        assign same_row = wr_hit && (wb_warp == bank.warp[b]) && (wb_off == bank.off[b]);

        always_ff @(posedge clk) begin
            for (int l = 0; l < oc_pkg::LANES; l++) begin
                if (wr_hit && wb_mask[l]) begin
                    mem[wb_warp][wb_off][l*oc_pkg::DATA_W +: oc_pkg::DATA_W] <=
                        wb_data[l*oc_pkg::DATA_W +: oc_pkg::DATA_W];
                end
                // Write-first, masked lanes come from the writeback
                if (bank.req[b]) begin
                    if (same_row && wb_mask[l]) begin
                        rdata_q[l*oc_pkg::DATA_W +: oc_pkg::DATA_W] <=
                            wb_data[l*oc_pkg::DATA_W +: oc_pkg::DATA_W];
                    end else begin
                        rdata_q[l*oc_pkg::DATA_W +: oc_pkg::DATA_W] <=
                            mem[bank.warp[b]][bank.off[b]][l*oc_pkg::DATA_W +: oc_pkg::DATA_W];
                    end
                end
            end
        end

        assign bank.rdata[b] = rdata_q;
    end

    // An unknown writeback row would land in no valid register
    a_wb_rd_known: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> !$isunknown({wb_warp, wb_rd}));

endmodule

// File: oc_release_stage.sv
`timescale 1ns/1ps

module oc_release_stage (
    input  logic             clk,
    input  logic             rst_n,
    oc_release_if.sink       rel,
    input  logic             ex_credit,
    output logic             ex_valid,
    output oc_pkg::warp_t    ex_warp,
    output oc_pkg::op_e      ex_op,
    output oc_pkg::reg_idx_t ex_rd,
    output oc_pkg::vreg_t    ex_rs1,
    output oc_pkg::vreg_t    ex_rs2
);

    oc_pkg::seq_t      next_rel [oc_pkg::NUM_WARPS];
    oc_pkg::unit_idx_t rr_ptr;
    oc_pkg::unit_idx_t sel;
    oc_pkg::credit_t   credits;
    logic              hit;
    logic              fire;

    // First ready unit that is next in its warp's issue order
    always_comb begin
        oc_pkg::unit_idx_t u;
        u   = '0;
        hit = 1'b0;
        sel = '0;
        for (int i = 0; i < oc_pkg::NUM_UNITS; i++) begin
            u = rr_ptr + oc_pkg::unit_idx_t'(i);
            if (!hit && rel.ready[u] && rel.seq[u] == next_rel[rel.warp[u]]) begin
                hit = 1'b1;
                sel = u;
            end
        end
    end

    assign fire           = hit && (credits != '0);
    assign rel.free_valid = fire;
    assign rel.free_unit  = sel;

    // Output mux, slots the op does not read go out as zero
    assign ex_valid = fire;
    assign ex_warp  = rel.warp[sel];
    assign ex_op    = rel.op[sel];
    assign ex_rd    = rel.rd[sel];
    assign ex_rs1   = rel.need[sel][0] ? rel.rs1_data[sel] : '0;
    assign ex_rs2   = rel.need[sel][1] ? rel.rs2_data[sel] : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rr_ptr  <= '0;
            credits <= oc_pkg::credit_t'(oc_pkg::EX_CREDITS);
            for (int w = 0; w < oc_pkg::NUM_WARPS; w++) begin
                next_rel[w] <= '0;
            end
        end else begin
            // One spent per release, one back per downstream pulse
            credits <= credits - oc_pkg::credit_t'(fire) + oc_pkg::credit_t'(ex_credit);
            if (fire) begin
                next_rel[rel.warp[sel]] <= next_rel[rel.warp[sel]] + 1'b1;
                rr_ptr                  <= sel + 1'b1;
            end
        end
    end

    // Downstream never returns more credits than it was given
    a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
        int'(credits) <= oc_pkg::EX_CREDITS);

endmodule

// File: oc_tb.sv
`timescale 1ns/1ps

module oc_tb;

    localparam int CYCLES      = 800;
    localparam int DRAIN_LIMIT = 500;

    // One expected release, operands frozen at dispatch
    typedef struct packed {
        oc_pkg::warp_t    warp;
        oc_pkg::op_e      op;
        oc_pkg::reg_idx_t rd;
        oc_pkg::reg_idx_t rs1;
        oc_pkg::reg_idx_t rs2;
        oc_pkg::need_t    need;
        oc_pkg::vreg_t    v1;
        oc_pkg::vreg_t    v2;
    } exp_t;

    logic               clk, rst_n;
    logic               dispatch_valid, dispatch_credit;
    oc_pkg::warp_t      dispatch_warp;
    oc_pkg::op_e        dispatch_op;
    oc_pkg::reg_idx_t   dispatch_rd, dispatch_rs1, dispatch_rs2;
    logic               wb_valid;
    oc_pkg::warp_t      wb_warp;
    oc_pkg::reg_idx_t   wb_rd;
    oc_pkg::lane_mask_t wb_mask;
    oc_pkg::vreg_t      wb_data;
    logic               ex_valid, ex_credit;
    oc_pkg::warp_t      ex_warp;
    oc_pkg::op_e        ex_op;
    oc_pkg::reg_idx_t   ex_rd;
    oc_pkg::vreg_t      ex_rs1, ex_rs2;

    // ==================================================
    // Model state
    // ==================================================
    oc_pkg::vreg_t model   [oc_pkg::NUM_WARPS][oc_pkg::NUM_REGS];
    // Unreleased instructions that still read each register
    int            readers [oc_pkg::NUM_WARPS][oc_pkg::NUM_REGS];
    exp_t          exp_q   [oc_pkg::NUM_WARPS][$];
    logic [31:0]   rng_state = 32'd41;
    int            disp_credits = oc_pkg::NUM_UNITS;
    int            n_dispatch = 0, n_release = 0, n_dcredit = 0;
    int            owed = 0, in_use = 0;
    int            mismatches = 0, failures = 0;
    logic          hold = 1'b0;

    tb_clock clk_gen_i (.clk(clk), .rst_n(rst_n));

    oc_top dut_i (.*);

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Source slots by opcode class
    function automatic oc_pkg::need_t sources_of(oc_pkg::op_e op);
        case (op)
            oc_pkg::OP_NOP, oc_pkg::OP_TID:                 return 2'b00;
            oc_pkg::OP_MOV, oc_pkg::OP_NOT, oc_pkg::OP_NEG: return 2'b01;
            default:                                        return 2'b11;
        endcase
    endfunction

    // Oldest outstanding instruction of warp w carries the released payload
    function automatic bit head_matches(input int w);
        exp_t h;
        if (exp_q[w].size() == 0) begin
            return 1'b0;
        end
        h = exp_q[w][0];
        return h.op === ex_op && h.rd === ex_rd && h.v1 === ex_rs1 && h.v2 === ex_rs2;
    endfunction

    // Warp whose oldest instruction was released, the reported warp when ambiguous
    function automatic int release_warp();
        int found;
        found = int'(ex_warp);
        if (!head_matches(found)) begin
            for (int w = 0; w < oc_pkg::NUM_WARPS; w++) begin
                if (head_matches(w)) begin
                    found = w;
                end
            end
        end
        return found;
    endfunction

    task automatic check_vreg(input string name, input oc_pkg::vreg_t got,
                              input oc_pkg::vreg_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_op(input string name, input oc_pkg::op_e got, input oc_pkg::op_e exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_warp(input string name, input oc_pkg::warp_t got,
                              input oc_pkg::warp_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_reg(input string name, input oc_pkg::reg_idx_t got,
                             input oc_pkg::reg_idx_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // ==================================================
    // Stimulus
    // ==================================================
    task automatic next_cycle();
        @(posedge clk);
        #1;
        dispatch_valid = 1'b0;
        wb_valid       = 1'b0;
        ex_credit      = 1'b0;
    endtask

    task automatic drive_writeback(input oc_pkg::warp_t w, input oc_pkg::reg_idx_t r,
                                   input oc_pkg::lane_mask_t m, input oc_pkg::vreg_t d);
        wb_valid = 1'b1;
        wb_warp  = w;
        wb_rd    = r;
        wb_mask  = m;
        wb_data  = d;
        for (int l = 0; l < oc_pkg::LANES; l++) begin
            if (m[l]) begin
                model[w][r][l*oc_pkg::DATA_W +: oc_pkg::DATA_W] =
                    d[l*oc_pkg::DATA_W +: oc_pkg::DATA_W];
            end
        end
    endtask

    task automatic drive_dispatch();
        exp_t e;
        e.warp = oc_pkg::warp_t'(next_rand());
        e.op   = oc_pkg::op_e'(4'(next_rand() % 10));
        e.rd   = oc_pkg::reg_idx_t'(next_rand());
        e.rs1  = oc_pkg::reg_idx_t'(next_rand());
        // Same bank at another offset now and then
        e.rs2  = (next_rand() % 4 == 0) ? e.rs1 ^ 4'h4 : oc_pkg::reg_idx_t'(next_rand());
        e.need = sources_of(e.op);
        e.v1   = e.need[0] ? model[e.warp][e.rs1] : '0;
        e.v2   = e.need[1] ? model[e.warp][e.rs2] : '0;
        if (e.need[0]) readers[e.warp][e.rs1] += 1;
        if (e.need[1]) readers[e.warp][e.rs2] += 1;
        exp_q[e.warp].push_back(e);
        dispatch_valid = 1'b1;
        dispatch_warp  = e.warp;
        dispatch_op    = e.op;
        dispatch_rd    = e.rd;
        dispatch_rs1   = e.rs1;
        dispatch_rs2   = e.rs2;
        disp_credits--;
        n_dispatch++;
    endtask

    // One cycle of random writeback, dispatch and credit return
    task automatic stimulate(input logic allow_dispatch);
        oc_pkg::warp_t    w;
        oc_pkg::reg_idx_t r;
        w = oc_pkg::warp_t'(next_rand());
        r = oc_pkg::reg_idx_t'(next_rand());
        if (next_rand() % 3 == 0 && readers[w][r] == 0) begin
            drive_writeback(w, r, oc_pkg::lane_mask_t'(next_rand()), {next_rand(), next_rand()});
        end
        if (allow_dispatch && disp_credits > 0 && next_rand() % 2 == 0) begin
            drive_dispatch();
        end
        if (!hold && owed > 0 && next_rand() % 3 == 0) begin
            ex_credit = 1'b1;
            owed--;
        end
        next_cycle();
    endtask

    initial begin
        int waited;
        dispatch_valid = 1'b0;
        dispatch_warp  = '0;
        dispatch_op    = oc_pkg::OP_NOP;
        dispatch_rd    = '0;
        dispatch_rs1   = '0;
        dispatch_rs2   = '0;
        wb_valid       = 1'b0;
        wb_warp        = '0;
        wb_rd          = '0;
        wb_mask        = '0;
        wb_data        = '0;
        ex_credit      = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        // Fill every register before anything reads it
        for (int w = 0; w < oc_pkg::NUM_WARPS; w++) begin
            for (int r = 0; r < oc_pkg::NUM_REGS; r++) begin
                drive_writeback(oc_pkg::warp_t'(w), oc_pkg::reg_idx_t'(r), '1,
                                {next_rand(), next_rand()});
                next_cycle();
            end
        end
        for (int c = 0; c < CYCLES; c++) begin
            // Downstream stalls for a while mid-run
            hold = (c >= 300 && c < 380);
            stimulate(1'b1);
        end
        hold   = 1'b0;
        waited = 0;
        while ((n_release < n_dispatch || disp_credits < oc_pkg::NUM_UNITS) &&
               waited < DRAIN_LIMIT) begin
            stimulate(1'b0);
            waited++;
        end
        if (waited >= DRAIN_LIMIT) begin
            failures++;
            $display("Timeout: instructions did not drain after %0d cycles", DRAIN_LIMIT);
        end
        if (n_dcredit != n_dispatch || disp_credits != oc_pkg::NUM_UNITS) begin
            failures++;
            $display("Dispatch credits: %0d pulses for %0d dispatches, %0d credits held",
                     n_dcredit, n_dispatch, disp_credits);
        end
        if (n_release != n_dispatch) begin
            failures++;
            $display("Released %0d instructions but dispatched %0d", n_release, n_dispatch);
        end
        for (int w = 0; w < oc_pkg::NUM_WARPS; w++) begin
            if (exp_q[w].size() != 0) begin
                failures++;
                $display("Warp %0d has %0d instructions never released", w, exp_q[w].size());
            end
        end
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches + failures == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // ==================================================
    // Monitor, outputs are settled at the falling edge
    // ==================================================
    always @(negedge clk) begin
        exp_t e;
        int   w_exp;
        if (rst_n) begin
            if (dispatch_credit) begin
                n_dcredit++;
                disp_credits++;
            end
            if (ex_valid) begin
                n_release++;
                owed++;
                in_use++;
                if (in_use > oc_pkg::EX_CREDITS) begin
                    failures++;
                    $display("Release without an execution credit, %0d outstanding", in_use);
                end
                w_exp = release_warp();
                if (exp_q[w_exp].size() == 0) begin
                    failures++;
                    $display("Release for warp %0d with nothing outstanding", ex_warp);
                end else begin
                    e = exp_q[w_exp].pop_front();
                    check_warp("ex_warp", ex_warp, e.warp);
                    check_op("ex_op", ex_op, e.op);
                    check_reg("ex_rd", ex_rd, e.rd);
                    check_vreg("ex_rs1", ex_rs1, e.v1);
                    check_vreg("ex_rs2", ex_rs2, e.v2);
                    if (e.need[0]) readers[e.warp][e.rs1] -= 1;
                    if (e.need[1]) readers[e.warp][e.rs2] -= 1;
                end
            end
            // Credit returned this cycle counts from the next edge
            if (ex_credit) in_use--;
        end
    end

endmodule

// File: oc_top.sv
`timescale 1ns/1ps

module oc_top (
    input  logic               clk,
    input  logic               rst_n,
    // Dispatch
    input  logic               dispatch_valid,
    input  oc_pkg::warp_t      dispatch_warp,
    input  oc_pkg::op_e        dispatch_op,
    input  oc_pkg::reg_idx_t   dispatch_rd,
    input  oc_pkg::reg_idx_t   dispatch_rs1,
    input  oc_pkg::reg_idx_t   dispatch_rs2,
    output logic               dispatch_credit,
    // Writeback
    input  logic               wb_valid,
    input  oc_pkg::warp_t      wb_warp,
    input  oc_pkg::reg_idx_t   wb_rd,
    input  oc_pkg::lane_mask_t wb_mask,
    input  oc_pkg::vreg_t      wb_data,
    // Execution
    output logic               ex_valid,
    output oc_pkg::warp_t      ex_warp,
    output oc_pkg::op_e        ex_op,
    output oc_pkg::reg_idx_t   ex_rd,
    output oc_pkg::vreg_t      ex_rs1,
    output oc_pkg::vreg_t      ex_rs2,
    input  logic               ex_credit
);

    oc_alloc_if   alloc_if ();
    oc_bank_if    bank_if ();
    oc_release_if rel_if ();

    oc_regfile regfile_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .bank     (bank_if),
        .wb_valid (wb_valid),
        .wb_warp  (wb_warp),
        .wb_rd    (wb_rd),
        .wb_mask  (wb_mask),
        .wb_data  (wb_data)
    );

    // Allocate, collect, release
    oc_alloc_stage alloc_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .dispatch_valid  (dispatch_valid),
        .dispatch_warp   (dispatch_warp),
        .dispatch_op     (dispatch_op),
        .dispatch_rd     (dispatch_rd),
        .dispatch_rs1    (dispatch_rs1),
        .dispatch_rs2    (dispatch_rs2),
        .free_valid      (rel_if.free_valid),
        .free_unit       (rel_if.free_unit),
        .alloc           (alloc_if),
        .dispatch_credit (dispatch_credit)
    );

    oc_collect_stage collect_i (
        .clk   (clk),
        .rst_n (rst_n),
        .alloc (alloc_if),
        .bank  (bank_if),
        .rel   (rel_if)
    );

    oc_release_stage release_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .rel       (rel_if),
        .ex_credit (ex_credit),
        .ex_valid  (ex_valid),
        .ex_warp   (ex_warp),
        .ex_op     (ex_op),
        .ex_rd     (ex_rd),
        .ex_rs1    (ex_rs1),
        .ex_rs2    (ex_rs2)
    );

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build the operand collector testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module oc_tb -f list.f -o oc_sim &&
./obj_dir/oc_sim | tee /dev/stderr | grep -qF '*** PASSED ***' &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// File: tb_clock.sv
`timescale 1ns/1ps

// Free-running 4 ns clock, reset held low for the first two edges
module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule
